//--- hdl/count_mem_arbiter.sv
`timescale 1ns/10ps
`include "rx_bist_settings.svh"

module count_mem_arbiter
    import rx_bist_pkg::*;
(
    input  logic          clk_adc,
    input  logic          cdr_rstb,
    count_mem_if.arbiter  hist_port,
    count_mem_if.arbiter  host_port
);

    localparam int NWORDS = 2 ** `RXB_NBIN_BITS;

    count_t    mem_q [NWORDS];
    logic      grant_hist;
    logic      grant_host;
    logic      granted;
    mem_op_e   sel_op;
    bin_addr_t sel_addr;
    count_t    sel_wdata;
    logic      hist_rsp_q;
    logic      host_rsp_q;
    count_t    rdata_q;

    //////////////////////////////////////////////////
    // fixed priority, histogram first
    //////////////////////////////////////////////////

    assign hist_port.req_ready = 1'b1;
    assign host_port.req_ready = !hist_port.req_valid;

    assign grant_hist = hist_port.req_valid;
    assign grant_host = host_port.req_valid && host_port.req_ready;
    assign granted    = grant_hist || grant_host;

    always_comb begin
        if (grant_hist) begin
            sel_op    = hist_port.req_op;
            sel_addr  = hist_port.req_addr;
            sel_wdata = hist_port.req_wdata;
        end else begin
            sel_op    = host_port.req_op;
            sel_addr  = host_port.req_addr;
            sel_wdata = host_port.req_wdata;
        end
    end

    // count storage, single port
    always_ff @(posedge clk_adc) begin
        if (granted && (sel_op == MEM_WRITE)) begin
            mem_q[sel_addr] <= sel_wdata;
        end
        if (granted && (sel_op == MEM_READ)) begin
            rdata_q <= mem_q[sel_addr];
        end
    end

    // response goes back to the granted port only
    always_ff @(posedge clk_adc or negedge cdr_rstb) begin
        if (!cdr_rstb) begin
            hist_rsp_q <= 1'b0;
            host_rsp_q <= 1'b0;
        end else begin
            hist_rsp_q <= grant_hist && (hist_port.req_op == MEM_READ);
            host_rsp_q <= grant_host && (host_port.req_op == MEM_READ);
        end
    end

    assign hist_port.rsp_valid = hist_rsp_q;
    assign hist_port.rsp_rdata = rdata_q;
    assign host_port.rsp_valid = host_rsp_q;
    assign host_port.rsp_rdata = rdata_q;

    a_one_rsp: assert property (
        @(posedge clk_adc) disable iff (!cdr_rstb) !(hist_port.rsp_valid && host_port.rsp_valid)
    );

endmodule

//--- hdl/count_mem_if.sv
`timescale 1ns/10ps

interface count_mem_if
    import rx_bist_pkg::*;
();

    // request channel, requester to arbiter except ready
    logic      req_valid;
    logic      req_ready;
    mem_op_e   req_op;
    bin_addr_t req_addr;
    count_t    req_wdata;

    // read return, one cycle after an accepted read
    logic      rsp_valid;
    count_t    rsp_rdata;

    modport requester (
        output req_valid, req_op, req_addr, req_wdata,
        input  req_ready, rsp_valid, rsp_rdata
    );

    modport arbiter (
        input  req_valid, req_op, req_addr, req_wdata,
        output req_ready, rsp_valid, rsp_rdata
    );

endinterface

//--- hdl/hist_engine.sv
`timescale 1ns/10ps
`include "rx_bist_settings.svh"

module hist_engine
    import rx_bist_pkg::*;
(
    input  logic                           clk_adc,
    input  logic                           cdr_rstb,
    input  logic                           en_i,
    input  logic [$clog2(`RXB_NLANES)-1:0] lane_i,
    input  logic                           clear_i,
    input  logic                           code_valid_i,
    output logic                           code_ready_o,
    input  adc_word_t                      codes_i,
    output logic                           busy_o,
    count_mem_if.requester                 mem
);

    hist_state_e state_q;
    logic        rd_pend_q;
    bin_addr_t   addr_q;
    count_t      cnt_q;
    adc_code_t   lane_code;
    bin_addr_t   lane_bin;
    logic        take_sample;
    logic        req_fire;
    logic        last_bin;

    // top bits of the code, MSB flipped so bin 0 is most negative
    assign lane_code = codes_i[lane_i];
    assign lane_bin  = {~lane_code[`RXB_NADC-1], lane_code[`RXB_NADC-2 -: `RXB_NBIN_BITS-1]};

    // one sample in flight at a time
    assign code_ready_o = !en_i || ((state_q == HIST_IDLE) && !clear_i);
    assign take_sample  = en_i && code_valid_i && code_ready_o;
    assign busy_o       = (state_q != HIST_IDLE);

    //////////////////////////////////////////////////
    // memory requests
    //////////////////////////////////////////////////

    assign mem.req_valid = ((state_q == HIST_READ) && !rd_pend_q) ||
                           (state_q == HIST_WRITE) || (state_q == HIST_CLEAR);
    assign mem.req_op    = (state_q == HIST_READ) ? MEM_READ : MEM_WRITE;
    assign mem.req_addr  = addr_q;
    assign mem.req_wdata = cnt_q;

    assign req_fire = mem.req_valid && mem.req_ready;
    assign last_bin = (addr_q == '1);

    always_ff @(posedge clk_adc or negedge cdr_rstb) begin
        if (!cdr_rstb) begin
            state_q   <= HIST_IDLE;
            rd_pend_q <= 1'b0;
        end else begin
            case (state_q)
                HIST_IDLE: begin
                    rd_pend_q <= 1'b0;
                    if (clear_i) begin
                        state_q <= HIST_CLEAR;
                    end else if (take_sample) begin
                        state_q <= HIST_READ;
                    end
                end
                HIST_READ: begin
                    if (req_fire) begin
                        rd_pend_q <= 1'b1;
                    end
                    if (mem.rsp_valid) begin
                        rd_pend_q <= 1'b0;
                        state_q   <= HIST_WRITE;
                    end
                end
                HIST_WRITE: begin
                    if (req_fire) begin
                        state_q <= HIST_IDLE;
                    end
                end
                default: begin
                    // walk every bin once
                    if (req_fire && last_bin) begin
                        state_q <= HIST_IDLE;
                    end
                end
            endcase
        end
    end

    // bin address and write value
    always_ff @(posedge clk_adc) begin
        if (state_q == HIST_IDLE) begin
            if (clear_i) begin
                addr_q <= '0;
                cnt_q  <= '0;
            end else if (take_sample) begin
                addr_q <= lane_bin;
            end
        end else if (state_q == HIST_CLEAR) begin
            if (req_fire) begin
                addr_q <= addr_q + 1'b1;
            end
        end else if ((state_q == HIST_READ) && mem.rsp_valid) begin
            // saturate at full scale
            cnt_q <= (mem.rsp_rdata == '1) ? mem.rsp_rdata : mem.rsp_rdata + 1'b1;
        end
    end

    a_rsp_in_read: assert property (
        @(posedge clk_adc) disable iff (!cdr_rstb) mem.rsp_valid |-> (state_q == HIST_READ)
    );

endmodule

//--- hdl/prbs_checker.sv
`timescale 1ns/10ps
`include "rx_bist_settings.svh"

module prbs_checker
    import rx_bist_pkg::*;
(
    input  logic                   clk_adc,
    input  logic                   cdr_rstb,
    input  logic                   adv_i,
    input  adc_word_t              codes_i,
    input  adc_code_t              thresh_i,
    input  bit_src_e               src_i,
    input  logic [`RXB_NLANES-1:0] bist_bits_i,
    input  logic                   clear_i,
    output prbs_cnt_t              err_count_o,
    output prbs_cnt_t              bit_count_o
);

    localparam int NERR_W = $clog2(`RXB_NLANES + 1);

    logic [`RXB_NLANES-1:0] adc_bits;
    logic [`RXB_NLANES-1:0] rx_bits;
    logic [6:0]             hist_q;
    logic [6:0]             hist_nxt;
    logic [NERR_W-1:0]      nerr;
    logic [1:0]             warm_q;
    logic                   counting;

    //////////////////////////////////////////////////
    // slicer and source select
    //////////////////////////////////////////////////

    always_comb begin
        for (int l = 0; l < `RXB_NLANES; l++) begin
            adc_bits[l] = (codes_i[l] >= thresh_i);
        end
    end

    assign rx_bits = (src_i == SRC_BIST) ? bist_bits_i : adc_bits;

    //////////////////////////////////////////////////
    // self-synchronizing check
    //////////////////////////////////////////////////

    // each bit against the XOR of the bits 7 and 6 back,
    // history built from the received stream itself
    always_comb begin
        hist_nxt = hist_q;
        nerr     = '0;
        for (int l = 0; l < `RXB_NLANES; l++) begin
            if (rx_bits[l] != (hist_nxt[6] ^ hist_nxt[5])) begin
                nerr = nerr + 1'b1;
            end
            hist_nxt = {hist_nxt[5:0], rx_bits[l]};
        end
    end

    // history is full from the third word on
    assign counting = (warm_q == 2'd2);

    always_ff @(posedge clk_adc or negedge cdr_rstb) begin
        if (!cdr_rstb) begin
            hist_q      <= '0;
            warm_q      <= '0;
            err_count_o <= '0;
            bit_count_o <= '0;
        end else begin
            if (adv_i) begin
                hist_q <= hist_nxt;
            end
            if (clear_i) begin
                warm_q      <= '0;
                err_count_o <= '0;
                bit_count_o <= '0;
            end else if (adv_i) begin
                if (counting) begin
                    err_count_o <= err_count_o + prbs_cnt_t'(nerr);
                    bit_count_o <= bit_count_o + prbs_cnt_t'(`RXB_NLANES);
                end else begin
                    warm_q <= warm_q + 2'd1;
                end
            end
        end
    end

    a_err_le_bits: assert property (
        @(posedge clk_adc) disable iff (!cdr_rstb) err_count_o <= bit_count_o
    );

endmodule

//--- hdl/prbs_gen.sv
`timescale 1ns/10ps
`include "rx_bist_settings.svh"

module prbs_gen (
    input  logic                   clk_adc,
    input  logic                   cdr_rstb,
    input  logic                   adv_i,
    input  logic                   inj_err_i,
    output logic [`RXB_NLANES-1:0] bits_o
);

    // last seven serial bits, bit 6 is the oldest
    logic [6:0]             state_q;
    logic [6:0]             state_nxt;
    logic [`RXB_NLANES-1:0] bits_nxt;

    // x^7+x^6+1 unrolled over one word, lane 0 first
    always_comb begin
        state_nxt = state_q;
        for (int l = 0; l < `RXB_NLANES; l++) begin
            bits_nxt[l] = state_nxt[6] ^ state_nxt[5];
            state_nxt   = {state_nxt[5:0], bits_nxt[l]};
        end
    end

    // flip lane 0 only, sequence itself unaffected
    assign bits_o = bits_nxt ^ {{(`RXB_NLANES-1){1'b0}}, inj_err_i};

    always_ff @(posedge clk_adc or negedge cdr_rstb) begin
        if (!cdr_rstb) begin
            state_q <= `RXB_PRBS_SEED;
        end else if (adv_i) begin
            state_q <= state_nxt;
        end
    end

    // an all-zero state would lock the sequence
    a_state_nonzero: assert property (
        @(posedge clk_adc) disable iff (!cdr_rstb) state_q != 7'd0
    );

endmodule

//--- hdl/rx_bist_pkg.sv
`include "rx_bist_settings.svh"

package rx_bist_pkg;

    // one signed ADC code and a full word of lanes
    typedef logic signed [`RXB_NADC-1:0] adc_code_t;
    typedef adc_code_t [`RXB_NLANES-1:0] adc_word_t;

    // histogram bin index and bin count
    typedef logic [`RXB_NBIN_BITS-1:0] bin_addr_t;
    typedef logic [`RXB_NCOUNT-1:0] count_t;

    // error and total bit counters
    typedef logic [`RXB_NPRBS_CNT-1:0] prbs_cnt_t;

    typedef enum logic {
        MEM_READ,
        MEM_WRITE
    } mem_op_e;

    // checker input select
    typedef enum logic {
        SRC_ADC,
        SRC_BIST
    } bit_src_e;

    typedef enum logic [1:0] {
        HIST_IDLE,
        HIST_READ,
        HIST_WRITE,
        HIST_CLEAR
    } hist_state_e;

endpackage

//--- hdl/rx_bist_settings.svh
`ifndef RX_BIST_SETTINGS_SVH
`define RX_BIST_SETTINGS_SVH

//////////////////////////////////////////////////
// datapath widths
//////////////////////////////////////////////////

// codes per accepted ADC word
`define RXB_NLANES 4

// signed ADC code width
`define RXB_NADC 8

// histogram bin index width, 16 bins
`define RXB_NBIN_BITS 4

// count memory word and PRBS counter widths
`define RXB_NCOUNT 16
`define RXB_NPRBS_CNT 32

// PRBS7 generator start state, must be nonzero
`define RXB_PRBS_SEED 7'h01

`endif

//--- hdl/rx_bist_top.sv
`timescale 1ns/10ps
`include "rx_bist_settings.svh"

module rx_bist_top
    import rx_bist_pkg::*;
(
    input  logic                           clk_adc,
    input  logic                           cdr_rstb,
    input  logic                           adc_valid_i,
    output logic                           adc_ready_o,
    input  adc_word_t                      adc_codes_i,
    input  adc_code_t                      slice_thresh_i,
    input  bit_src_e                       bit_src_i,
    input  logic                           inj_err_i,
    input  logic                           prbs_clear_i,
    output prbs_cnt_t                      err_count_o,
    output prbs_cnt_t                      bit_count_o,
    input  logic                           hist_en_i,
    input  logic [$clog2(`RXB_NLANES)-1:0] hist_lane_i,
    input  logic                           hist_clear_i,
    output logic                           hist_busy_o,
    input  logic                           rd_valid_i,
    output logic                           rd_ready_o,
    input  bin_addr_t                      rd_addr_i,
    output count_t                         rd_data_o,
    output logic                           rd_data_valid_o
);

    logic                   word_acc;
    logic [`RXB_NLANES-1:0] bist_bits;

    count_mem_if hist_bus ();
    count_mem_if host_bus ();

    // whole stream advances on an accepted word only
    assign word_acc = adc_valid_i && adc_ready_o;

    //////////////////////////////////////////////////
    // host read port
    //////////////////////////////////////////////////

    assign host_bus.req_valid = rd_valid_i;
    assign host_bus.req_op    = MEM_READ;
    assign host_bus.req_addr  = rd_addr_i;
    assign host_bus.req_wdata = '0;
    assign rd_ready_o         = host_bus.req_ready;
    assign rd_data_o          = host_bus.rsp_rdata;
    assign rd_data_valid_o    = host_bus.rsp_valid;

    prbs_gen prbs_gen_i (
        .clk_adc   (clk_adc),
        .cdr_rstb  (cdr_rstb),
        .adv_i     (word_acc),
        .inj_err_i (inj_err_i),
        .bits_o    (bist_bits)
    );

    prbs_checker prbs_checker_i (
        .clk_adc     (clk_adc),
        .cdr_rstb    (cdr_rstb),
        .adv_i       (word_acc),
        .codes_i     (adc_codes_i),
        .thresh_i    (slice_thresh_i),
        .src_i       (bit_src_i),
        .bist_bits_i (bist_bits),
        .clear_i     (prbs_clear_i),
        .err_count_o (err_count_o),
        .bit_count_o (bit_count_o)
    );

    // histogram engine sets the stream back-pressure
    hist_engine hist_engine_i (
        .clk_adc      (clk_adc),
        .cdr_rstb     (cdr_rstb),
        .en_i         (hist_en_i),
        .lane_i       (hist_lane_i),
        .clear_i      (hist_clear_i),
        .code_valid_i (adc_valid_i),
        .code_ready_o (adc_ready_o),
        .codes_i      (adc_codes_i),
        .busy_o       (hist_busy_o),
        .mem          (hist_bus)
    );

    count_mem_arbiter count_mem_arbiter_i (
        .clk_adc   (clk_adc),
        .cdr_rstb  (cdr_rstb),
        .hist_port (hist_bus),
        .host_port (host_bus)
    );

endmodule

//--- run_sim.sh
#!/bin/sh
# build with Verilator and run the testbench from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module tb_rx_bist -f rx_bist.f || { echo "build failed"; exit 1; }
out=$(./obj_dir/Vtb_rx_bist 2>&1)
echo "$out"
echo "$out" | grep -qF '** PASS **' && echo "simulation passed" || { echo "simulation failed"; exit 1; }

//--- rx_bist.f
+incdir+hdl
hdl/rx_bist_pkg.sv
hdl/count_mem_if.sv
hdl/prbs_gen.sv
hdl/prbs_checker.sv
hdl/hist_engine.sv
hdl/count_mem_arbiter.sv
hdl/rx_bist_top.sv
sim/tb_rx_bist.sv

//--- sim/rx_bist_tests.txt
# word c0 c1 c2 c3 (hex, lane 0 first) | src n | inj n | hist_on lane | thresh t (hex)
# check_prbs errors bits | read addr count (decimal) | prbs_clear and hist_clear take no argument
src 1
prbs_clear
word 00 00 00 00
word 00 00 00 00
word 00 00 00 00
word 00 00 00 00
word 00 00 00 00
word 00 00 00 00
check_prbs 0 16
inj 1
word 00 00 00 00
inj 0
word 00 00 00 00
word 00 00 00 00
check_prbs 3 28
# ADC slicing against 0x10 with the histogram on lane 2
src 0
thresh 10
hist_clear
hist_on 2
prbs_clear
word 7f 0f 10 35
word 80 f0 22 00
word 40 10 a5 7f
word 0f 80 05 ff
word 20 55 1c 10
word c0 11 80 60
word 10 ee 7f 0a
check_prbs 12 20
read 0 1
read 1 0
read 2 1
read 3 0
read 4 0
read 5 0
read 6 0
read 7 0
read 8 1
read 9 2
read 10 1
read 11 0
read 12 0
read 13 0
read 14 0
read 15 1

//--- sim/tb_rx_bist.sv
`timescale 1ns/10ps
`include "rx_bist_settings.svh"

module tb_rx_bist
    import rx_bist_pkg::*;
();

    localparam string TESTS_FILE = "sim/rx_bist_tests.txt";

    logic                           clk_adc;
    logic                           cdr_rstb;
    logic                           adc_valid_i;
    logic                           adc_ready_o;
    adc_word_t                      adc_codes_i;
    adc_code_t                      slice_thresh_i;
    bit_src_e                       bit_src_i;
    logic                           inj_err_i;
    logic                           prbs_clear_i;
    prbs_cnt_t                      err_count_o;
    prbs_cnt_t                      bit_count_o;
    logic                           hist_en_i;
    logic [$clog2(`RXB_NLANES)-1:0] hist_lane_i;
    logic                           hist_clear_i;
    logic                           hist_busy_o;
    logic                           rd_valid_i;
    logic                           rd_ready_o;
    bin_addr_t                      rd_addr_i;
    count_t                         rd_data_o;
    logic                           rd_data_valid_o;
    int                             cycles = 0;
    int                             limit = 200;

    rx_bist_top uut (.*);

    initial begin
        clk_adc = 1'b0;
        forever #4 clk_adc = ~clk_adc;
    end

    // cycle watchdog against a limit from the tests file length
    always @(posedge clk_adc) begin
        cycles <= cycles + 1;
        if (cycles > limit) begin
            $display("timeout: the run did not finish within %0d cycles", limit);
            $display("** FAIL **");
            $fatal(1, "simulation stopped by the watchdog");
        end
    end

    //////////////////////////////////////////////////
    // compare tasks
    //////////////////////////////////////////////////

    task automatic check_prbs_cnt(input string name, input prbs_cnt_t got, input prbs_cnt_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
            $display("** FAIL **");
            $fatal(1, "counter mismatch");
        end
    endtask

    task automatic check_count(input string name, input count_t got, input count_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
            $display("** FAIL **");
            $fatal(1, "histogram count mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
            $display("** FAIL **");
            $fatal(1, "status flag mismatch");
        end
    endtask

    task automatic bad_line(input logic [127:0] cmd);
        $display("tests file line for command '%0s' is malformed or unknown", cmd);
        $display("** FAIL **");
        $fatal(1, "cannot parse the tests file");
    endtask

    //////////////////////////////////////////////////
    // bus tasks
    //////////////////////////////////////////////////

    // outputs are sampled on the falling edge
    task automatic wait_idle();
        @(negedge clk_adc);
        while (hist_busy_o) @(negedge clk_adc);
    endtask

    task automatic send_word(input adc_word_t w);
        @(posedge clk_adc);
        adc_valid_i <= 1'b1;
        adc_codes_i <= w;
        @(negedge clk_adc);
        while (!adc_ready_o) @(negedge clk_adc);
        // accepted on this edge
        @(posedge clk_adc);
        adc_valid_i <= 1'b0;
    endtask

    task automatic read_bin(input bin_addr_t addr, input count_t exp);
        wait_idle();
        @(posedge clk_adc);
        rd_valid_i <= 1'b1;
        rd_addr_i  <= addr;
        @(negedge clk_adc);
        while (!rd_ready_o) @(negedge clk_adc);
        @(posedge clk_adc);
        rd_valid_i <= 1'b0;
        @(negedge clk_adc);
        while (!rd_data_valid_o) @(negedge clk_adc);
        check_count("rd_data_o", rd_data_o, exp);
    endtask

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////

    initial begin
        int            fd;
        int            r;
        int            nlines;
        int            a;
        int            b;
        logic [127:0]  cmd;
        logic [1023:0] line;
        adc_code_t     c0;
        adc_code_t     c1;
        adc_code_t     c2;
        adc_code_t     c3;
        adc_word_t     w;
        logic          done;

        cdr_rstb       = 1'b0;
        adc_valid_i    = 1'b0;
        adc_codes_i    = '0;
        slice_thresh_i = '0;
        bit_src_i      = SRC_ADC;
        inj_err_i      = 1'b0;
        prbs_clear_i   = 1'b0;
        hist_en_i      = 1'b0;
        hist_lane_i    = '0;
        hist_clear_i   = 1'b0;
        rd_valid_i     = 1'b0;
        rd_addr_i      = '0;

        fd = $fopen(TESTS_FILE, "r");
        if (fd == 0) begin
            $display("cannot open %s", TESTS_FILE);
            $display("** FAIL **");
            $fatal(1, "missing tests file");
        end
        nlines = 0;
        while ($fgets(line, fd) != 0) nlines++;
        $fclose(fd);
        limit = 40 * nlines + 200;
        fd = $fopen(TESTS_FILE, "r");

        repeat (2) @(posedge clk_adc);
        cdr_rstb <= 1'b1;

        // state right after reset
        @(negedge clk_adc);
        check_prbs_cnt("err_count_o", err_count_o, '0);
        check_prbs_cnt("bit_count_o", bit_count_o, '0);
        check_flag("rd_data_valid_o", rd_data_valid_o, 1'b0);
        check_flag("hist_busy_o", hist_busy_o, 1'b0);
        check_flag("adc_ready_o", adc_ready_o, 1'b1);
        check_flag("rd_ready_o", rd_ready_o, 1'b1);

        done = 1'b0;
        while (!done) begin
            cmd = '0;
            r = $fscanf(fd, "%s", cmd);
            if (r != 1) begin
                done = 1'b1;
            end else if (cmd == "#") begin
                r = $fgets(line, fd);
            end else if (cmd == "word") begin
                r = $fscanf(fd, "%h %h %h %h", c0, c1, c2, c3);
                if (r != 4) bad_line(cmd);
                w[0] = c0;
                w[1] = c1;
                w[2] = c2;
                w[3] = c3;
                send_word(w);
            end else if (cmd == "src" || cmd == "inj" || cmd == "hist_on") begin
                r = $fscanf(fd, "%d", a);
                if (r != 1) bad_line(cmd);
                @(posedge clk_adc);
                if (cmd == "src") begin
                    bit_src_i <= bit_src_e'(a);
                end else if (cmd == "inj") begin
                    inj_err_i <= a[0];
                end else begin
                    hist_en_i   <= 1'b1;
                    hist_lane_i <= a[$clog2(`RXB_NLANES)-1:0];
                end
            end else if (cmd == "thresh") begin
                r = $fscanf(fd, "%h", c0);
                if (r != 1) bad_line(cmd);
                @(posedge clk_adc);
                slice_thresh_i <= c0;
            end else if (cmd == "prbs_clear") begin
                @(posedge clk_adc);
                prbs_clear_i <= 1'b1;
                @(posedge clk_adc);
                prbs_clear_i <= 1'b0;
            end else if (cmd == "hist_clear") begin
                // engine takes a clear only when idle
                wait_idle();
                @(posedge clk_adc);
                hist_clear_i <= 1'b1;
                @(posedge clk_adc);
                hist_clear_i <= 1'b0;
                wait_idle();
            end else if (cmd == "check_prbs") begin
                r = $fscanf(fd, "%d %d", a, b);
                if (r != 2) bad_line(cmd);
                wait_idle();
                check_prbs_cnt("err_count_o", err_count_o, prbs_cnt_t'(a));
                check_prbs_cnt("bit_count_o", bit_count_o, prbs_cnt_t'(b));
            end else if (cmd == "read") begin
                r = $fscanf(fd, "%d %d", a, b);
                if (r != 2) bad_line(cmd);
                read_bin(bin_addr_t'(a), count_t'(b));
            end else begin
                bad_line(cmd);
            end
        end
        $fclose(fd);

        $display("** PASS **");
        $finish;
    end

endmodule
